/* hdl/nes_cart_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Shared types for the cartridge front end: bytes, ROM addresses,
// iNES header, mapper flags, cheat code and pad buttons
// Loader states and fixed layout constants
////////////////////////////////////////////////////////////////////////////

package nes_cart_pkg;

	typedef logic [7:0]   byte_t;
	typedef logic [21:0]  rom_addr_t;
	typedef logic [21:0]  rom_count_t;
	typedef logic [127:0] ines_header_t;      // Byte 0 in bits 7:0
	typedef logic [7:0]   pad_buttons_t;      // A B Sel Start Up Down Left Right, bit 0 first

	// Flags word handed to the mapper logic, mapper number in the low byte
	typedef struct packed {
		logic [5:0] reserved;
		logic       has_saves;
		logic [7:0] submapper;
		logic       four_screen;
		logic       chr_ram;
		logic       mirroring;
		logic [2:0] chr_size;
		logic [2:0] prg_size;
		logic [7:0] mapper;
	} mapper_flags_t;

	// Each field little-endian in the cheat file
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	typedef enum logic [2:0] {
		S_HEADER,
		S_PRG,
		S_CHR,
		S_DONE,
		S_ERROR
	} loader_state_e;

	localparam int HEADER_BYTES   = 16;
	localparam int PRG_PAGE_SHIFT = 14;       // 16 KiB pages
	localparam int CHR_PAGE_SHIFT = 13;       // 8 KiB pages

	localparam rom_addr_t CHR_BASE         = 22'h200000;
	localparam byte_t     CHEAT_FILE_INDEX = 8'hFF;

	// Four-player adapter signatures
	localparam byte_t TAP_ID_PORT1 = 8'h08;
	localparam byte_t TAP_ID_PORT2 = 8'h04;

	// "NES" then 0x1A, first byte lowest
	localparam logic [31:0] INES_MAGIC = 32'h1A53_454E;

endpackage

/* hdl/ines_decode.sv */
////////////////////////////////////////////////////////////////////////////
// iNES header decode: magic and trainer check, NES 2.0 and dirty
// header detection, PRG/CHR byte counts and mapper flags packing
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ines_decode (
	input  nes_cart_pkg::ines_header_t  header,
	input  logic                        invert_mirroring,
	output logic                        header_ok,
	output nes_cart_pkg::rom_count_t    prg_bytes,
	output nes_cart_pkg::rom_count_t    chr_bytes,
	output nes_cart_pkg::mapper_flags_t flags
);
	import nes_cart_pkg::*;

	byte_t hb [HEADER_BYTES];
	logic  is_nes20;
	logic  is_dirty;

	// Ceiling log2 of a page count, saturating at 7
	function automatic logic [2:0] size_code(input byte_t pages);
		logic [2:0] code;
		code = 3'd7;
		for (int i = 6; i >= 0; i--) begin
			if (pages <= (9'd1 << i))
				code = 3'(i);
		end
		return code;
	endfunction

	always_comb begin
		for (int i = 0; i < HEADER_BYTES; i++)
			hb[i] = header[i*8 +: 8];
	end

	// No trainer support
	assign header_ok = ({hb[3], hb[2], hb[1], hb[0]} == INES_MAGIC) && !hb[6][2];

	assign is_nes20 = (hb[7][3:2] == 2'b10);

	// Junk in the tail of an old header, usually a ripper tag
	assign is_dirty = !is_nes20 && ((hb[9][7:1] != 7'd0) || (header[127:80] != '0));

	assign prg_bytes = rom_count_t'(hb[4]) << PRG_PAGE_SHIFT;
	assign chr_bytes = rom_count_t'(hb[5]) << CHR_PAGE_SHIFT;

	always_comb begin
		flags             = '0;
		flags.mapper      = {is_dirty ? 4'h0 : hb[7][7:4], hb[6][7:4]};
		flags.prg_size    = size_code(hb[4]);
		flags.chr_size    = size_code(hb[5]);
		flags.mirroring   = hb[6][0] ^ invert_mirroring;
		flags.chr_ram     = (hb[5] == 8'd0);    // No CHR ROM, board has RAM
		flags.four_screen = hb[6][3];
		flags.submapper   = is_nes20 ? hb[8] : 8'd0;
		flags.has_saves   = hb[6][1];
	end

endmodule

/* hdl/rom_loader.sv */
////////////////////////////////////////////////////////////////////////////
// ROM loader: captures the iNES header, then streams PRG and CHR
// bytes into cartridge memory as registered writes
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rom_loader (
	input  logic                        clk,
	input  logic                        reset_nes,
	input  logic                        rom_download,
	input  nes_cart_pkg::byte_t         file_byte,
	input  logic                        byte_strobe,
	input  logic                        invert_mirroring,
	output nes_cart_pkg::rom_addr_t     mem_addr,
	output nes_cart_pkg::byte_t         mem_data,
	output logic                        mem_write,
	output nes_cart_pkg::mapper_flags_t mapper_flags,
	output logic                        loader_busy,
	output logic                        loader_done,
	output logic                        loader_fail
);
	import nes_cart_pkg::*;

	loader_state_e state;
	ines_header_t  header;
	logic [3:0]    hdr_count;
	logic [3:0]    hdr_index;
	logic          header_full;       // All 16 bytes in, check next cycle
	logic          download_d;
	rom_addr_t     addr_cnt;
	rom_count_t    bytes_left;

	logic          header_ok;
	rom_count_t    prg_bytes;
	rom_count_t    chr_bytes;
	mapper_flags_t decoded_flags;

	logic          start;
	logic          take_header;
	logic          take_data;

	ines_decode decode_i (
		.header           (header),
		.invert_mirroring (invert_mirroring),
		.header_ok        (header_ok),
		.prg_bytes        (prg_bytes),
		.chr_bytes        (chr_bytes),
		.flags            (decoded_flags)
	);

	assign start       = rom_download && !download_d;
	assign hdr_index   = start ? 4'd0 : hdr_count;
	assign take_header = rom_download && byte_strobe &&
	                     (start || (state == S_HEADER && !header_full));
	assign take_data   = rom_download && byte_strobe && !start &&
	                     (state == S_PRG || state == S_CHR) && (bytes_left != '0);

	////////////////////////////////////////////////////////////////////////////
	// Control

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			state        <= S_HEADER;
			hdr_count    <= 4'd0;
			header_full  <= 1'b0;
			download_d   <= 1'b0;
			addr_cnt     <= '0;
			bytes_left   <= '0;
			mem_write    <= 1'b0;
			mapper_flags <= '0;
			loader_busy  <= 1'b0;
			loader_done  <= 1'b0;
			loader_fail  <= 1'b0;
		end else begin
			download_d <= rom_download;
			mem_write  <= take_data;

			if (start) begin                // New image, first byte may arrive now
				state       <= S_HEADER;
				hdr_count   <= take_header ? 4'd1 : 4'd0;
				header_full <= 1'b0;
				loader_busy <= 1'b0;
				loader_done <= 1'b0;
				loader_fail <= 1'b0;
			end else begin
				case (state)
					S_HEADER: begin
						if (header_full) begin
							header_full <= 1'b0;
							loader_busy <= 1'b1;
							addr_cnt    <= '0;
							bytes_left  <= prg_bytes;
							state       <= header_ok ? S_PRG : S_ERROR;
						end else if (take_header) begin
							hdr_count   <= hdr_count + 4'd1;
							header_full <= (hdr_count == 4'(HEADER_BYTES - 1));
						end
					end
					S_PRG, S_CHR: begin
						if (bytes_left != '0) begin
							if (take_data) begin
								addr_cnt   <= addr_cnt + 22'd1;
								bytes_left <= bytes_left - 22'd1;
							end
						end else if (state == S_PRG) begin
							state      <= S_CHR;
							addr_cnt   <= CHR_BASE;
							bytes_left <= chr_bytes;
						end else begin
							state        <= S_DONE;
							loader_busy  <= 1'b0;
							loader_done  <= 1'b1;
							mapper_flags <= decoded_flags;
						end
					end
					S_ERROR: begin
						loader_busy <= 1'b0;
						loader_done <= 1'b1;
						loader_fail <= 1'b1;
					end
					default: ;                  // Idle in S_DONE until the next image
				endcase
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Header capture and write data

	always_ff @(posedge clk) begin
		if (take_header)
			header[{hdr_index, 3'b000} +: 8] <= file_byte;
		if (take_data) begin
			mem_addr <= addr_cnt;
			mem_data <= file_byte;
		end
	end

endmodule

/* hdl/cheat_assembler.sv */
////////////////////////////////////////////////////////////////////////////
// Cheat code assembler: 16 file bytes into one 128-bit code
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module cheat_assembler (
	input  logic                      clk,
	input  logic                      reset_nes,
	input  logic                      cheat_download,
	input  nes_cart_pkg::byte_t       file_byte,
	input  logic                      byte_strobe,
	output nes_cart_pkg::cheat_code_t cheat_code,
	output logic                      cheat_valid
);
	import nes_cart_pkg::*;

	logic [3:0] offset;
	logic       take;

	assign take = cheat_download && byte_strobe;

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			offset      <= 4'd0;
			cheat_valid <= 1'b0;
		end else begin
			cheat_valid <= take && (offset == 4'd15);
			if (!cheat_download)
				offset <= 4'd0;
			else if (take)
				offset <= offset + 4'd1;            // Wraps to the next code
		end
	end

	// Offset bits 3:2 pick the field, 1:0 the byte within it
	always_ff @(posedge clk) begin
		if (take) begin
			case (offset[3:2])
				2'd0:    cheat_code.flags[{offset[1:0], 3'b000} +: 8]   <= file_byte;
				2'd1:    cheat_code.address[{offset[1:0], 3'b000} +: 8] <= file_byte;
				2'd2:    cheat_code.compare[{offset[1:0], 3'b000} +: 8] <= file_byte;
				default: cheat_code.replace[{offset[1:0], 3'b000} +: 8] <= file_byte;
			endcase
		end
	end

endmodule

/* hdl/joypad_serializer.sv */
////////////////////////////////////////////////////////////////////////////
// Controller ports: latch two pads or a four-player adapter,
// shift out on falling edges of the console's controller clocks
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module joypad_serializer (
	input  logic                       clk,
	input  logic                       reset_nes,
	input  logic                       joy_swap,
	input  logic                       multitap,
	input  nes_cart_pkg::pad_buttons_t pad_a,
	input  nes_cart_pkg::pad_buttons_t pad_b,
	input  nes_cart_pkg::pad_buttons_t pad_c,
	input  nes_cart_pkg::pad_buttons_t pad_d,
	input  logic                       joypad_strobe,
	input  logic [1:0]                 joypad_clock,
	output logic [1:0]                 joypad_data
);
	import nes_cart_pkg::*;

	logic [1:0][23:0] port_bits;
	logic [1:0][23:0] load_word;
	logic [1:0]       clock_d;
	logic [1:0]       clock_fall;

	// Without the adapter the upper 16 bits read back as ones
	assign load_word[0] = {multitap ? {TAP_ID_PORT1, pad_c} : 16'hFFFF,
	                       joy_swap ? pad_b : pad_a};
	assign load_word[1] = {multitap ? {TAP_ID_PORT2, pad_d} : 16'hFFFF,
	                       joy_swap ? pad_a : pad_b};

	assign clock_fall = clock_d & ~joypad_clock;

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			port_bits <= '0;
			clock_d   <= 2'b00;
		end else begin
			clock_d <= joypad_clock;
			for (int i = 0; i < 2; i++) begin
				if (joypad_strobe)
					port_bits[i] <= load_word[i];
				else if (clock_fall[i])
					port_bits[i] <= {1'b0, port_bits[i][23:1]};   // Zero fill after last bit
			end
		end
	end

	assign joypad_data[0] = port_bits[0][0];
	assign joypad_data[1] = port_bits[1][0];

endmodule

/* hdl/cart_frontend.sv */
////////////////////////////////////////////////////////////////////////////
// Cartridge front end top: download routing by file type,
// ROM loader, cheat assembler and controller serializer
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module cart_frontend (
	input  logic                        clk,
	input  logic                        reset_nes,
	input  logic                        download,
	input  nes_cart_pkg::byte_t         file_index,
	input  nes_cart_pkg::byte_t         file_byte,
	input  logic                        byte_strobe,
	input  logic                        invert_mirroring,
	input  logic                        joy_swap,
	input  logic                        multitap,
	input  nes_cart_pkg::pad_buttons_t  pad_a,
	input  nes_cart_pkg::pad_buttons_t  pad_b,
	input  nes_cart_pkg::pad_buttons_t  pad_c,
	input  nes_cart_pkg::pad_buttons_t  pad_d,
	input  logic                        joypad_strobe,
	input  logic [1:0]                  joypad_clock,
	output nes_cart_pkg::rom_addr_t     mem_addr,
	output nes_cart_pkg::byte_t         mem_data,
	output logic                        mem_write,
	output nes_cart_pkg::mapper_flags_t mapper_flags,
	output logic                        loader_busy,
	output logic                        loader_done,
	output logic                        loader_fail,
	output nes_cart_pkg::cheat_code_t   cheat_code,
	output logic                        cheat_valid,
	output logic [1:0]                  joypad_data
);
	import nes_cart_pkg::*;

	logic is_cheat;
	logic rom_download;
	logic cheat_download;

	// One compare, both blocks see the same bytes
	assign is_cheat       = (file_index == CHEAT_FILE_INDEX);
	assign cheat_download = download && is_cheat;
	assign rom_download   = download && !is_cheat;

	rom_loader loader_i (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.rom_download     (rom_download),
		.file_byte        (file_byte),
		.byte_strobe      (byte_strobe),
		.invert_mirroring (invert_mirroring),
		.mem_addr         (mem_addr),
		.mem_data         (mem_data),
		.mem_write        (mem_write),
		.mapper_flags     (mapper_flags),
		.loader_busy      (loader_busy),
		.loader_done      (loader_done),
		.loader_fail      (loader_fail)
	);

	cheat_assembler cheat_i (
		.clk            (clk),
		.reset_nes      (reset_nes),
		.cheat_download (cheat_download),
		.file_byte      (file_byte),
		.byte_strobe    (byte_strobe),
		.cheat_code     (cheat_code),
		.cheat_valid    (cheat_valid)
	);

	joypad_serializer joypad_i (
		.clk           (clk),
		.reset_nes     (reset_nes),
		.joy_swap      (joy_swap),
		.multitap      (multitap),
		.pad_a         (pad_a),
		.pad_b         (pad_b),
		.pad_c         (pad_c),
		.pad_d         (pad_d),
		.joypad_strobe (joypad_strobe),
		.joypad_clock  (joypad_clock),
		.joypad_data   (joypad_data)
	);

endmodule

/* tests/tb_cart_frontend.sv */
////////////////////////////////////////////////////////////////////////////
// Directed testbench for the cartridge front end covering ROM loads,
// header variants and rejects, cheat code assembly, controller shifting
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_cart_frontend;
	import nes_cart_pkg::*;

	localparam int TIMEOUT_CYCLES = 200;

	logic          clk;
	logic          reset_nes;
	logic          download;
	byte_t         file_index;
	byte_t         file_byte;
	logic          byte_strobe;
	logic          invert_mirroring;
	logic          joy_swap;
	logic          multitap;
	pad_buttons_t  pad_a;
	pad_buttons_t  pad_b;
	pad_buttons_t  pad_c;
	pad_buttons_t  pad_d;
	logic          joypad_strobe;
	logic [1:0]    joypad_clock;
	rom_addr_t     mem_addr;
	byte_t         mem_data;
	logic          mem_write;
	mapper_flags_t mapper_flags;
	logic          loader_busy;
	logic          loader_done;
	logic          loader_fail;
	cheat_code_t   cheat_code;
	logic          cheat_valid;
	logic [1:0]    joypad_data;

	int            error_count;
	int            check_count;
	int            tests_run;
	logic          timed_out;
	logic [31:0]   rng;
	byte_t         exp_mem [rom_addr_t];  // Expected memory, keyed by address
	rom_addr_t     cap_addr [$];
	byte_t         cap_data [$];
	int            valid_pulses = 0;

	cart_frontend dut_i (.*);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	// Every memory write and cheat strobe sampled mid-cycle
	always @(negedge clk) begin
		if (mem_write) begin
			cap_addr.push_back(mem_addr);
			cap_data.push_back(mem_data);
		end
		if (cheat_valid)
			valid_pulses++;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks

	task automatic check_flags(input string name, input mapper_flags_t got,
	                           input mapper_flags_t exp);
		check_count++;
		if (got !== exp) begin
			$display("ERROR %0t %s: got %h, expected %h", $time, name, got, exp);
			error_count++;
		end
	endtask

	task automatic check_addr(input string name, input rom_addr_t got, input rom_addr_t exp);
		check_count++;
		if (got !== exp) begin
			$display("ERROR %0t %s: got %h, expected %h", $time, name, got, exp);
			error_count++;
		end
	endtask

	task automatic check_byte(input string name, input byte_t got, input byte_t exp);
		check_count++;
		if (got !== exp) begin
			$display("ERROR %0t %s: got %h, expected %h", $time, name, got, exp);
			error_count++;
		end
	endtask

	task automatic check_code(input string name, input cheat_code_t got,
	                          input cheat_code_t exp);
		check_count++;
		if (got !== exp) begin
			$display("ERROR %0t %s: got %h, expected %h", $time, name, got, exp);
			error_count++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		check_count++;
		if (got !== exp) begin
			$display("ERROR %0t %s: got %b, expected %b", $time, name, got, exp);
			error_count++;
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests_run++;
		$display("%-16s finished with %0d errors", name, error_count - errs_before);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus helpers

	task automatic send_byte(input byte_t b);
		@(posedge clk);
		file_byte   <= b;
		byte_strobe <= 1'b1;
		@(posedge clk);
		byte_strobe <= 1'b0;                // Idle cycle between strobes
	endtask

	task automatic start_download(input byte_t index);
		@(posedge clk);
		file_index <= index;
		download   <= 1'b1;
	endtask

	task automatic end_download();
		@(posedge clk);
		download <= 1'b0;
		@(negedge clk);
	endtask

	// Header followed by random PRG and CHR bytes recorded in the memory model
	task automatic send_file(input ines_header_t h, input int prg_len, input int chr_len);
		byte_t     b;
		rom_addr_t a;
		start_download(8'h00);
		for (int i = 0; i < HEADER_BYTES; i++)
			send_byte(h[i*8 +: 8]);
		for (int i = 0; i < prg_len + chr_len; i++) begin
			rng = xorshift32(rng);
			b   = rng[7:0];
			a   = (i < prg_len) ? rom_addr_t'(i) : CHR_BASE + rom_addr_t'(i - prg_len);
			exp_mem[a] = b;
			send_byte(b);
		end
	endtask

	task automatic wait_done(output logic seen);
		seen = 1'b0;
		for (int cycles = 0; cycles < TIMEOUT_CYCLES && !seen; cycles++) begin
			@(negedge clk);
			seen = loader_done;
		end
		if (!seen) begin
			$display("Timeout at %0t: loader_done never rose", $time);
			error_count++;
			timed_out = 1'b1;
		end
	endtask

	task automatic wait_cheat_valid(input int base, output logic seen);
		seen = 1'b0;
		for (int cycles = 0; cycles < TIMEOUT_CYCLES && !seen; cycles++) begin
			@(negedge clk);
			seen = (valid_pulses != base);
		end
		if (!seen) begin
			$display("Timeout at %0t: cheat_valid never pulsed", $time);
			error_count++;
			timed_out = 1'b1;
		end
	endtask

	task automatic expect_no_writes(input int base);
		if (cap_addr.size() != base) begin
			$display("Memory was written %0d times where no write was allowed",
			         cap_addr.size() - base);
			error_count++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Tests

	task automatic reset_values();
		int errs;
		errs = error_count;
		check_bit("mem_write", mem_write, 1'b0);
		check_bit("loader_busy", loader_busy, 1'b0);
		check_bit("loader_done", loader_done, 1'b0);
		check_bit("loader_fail", loader_fail, 1'b0);
		check_bit("cheat_valid", cheat_valid, 1'b0);
		check_bit("joypad_data[0]", joypad_data[0], 1'b0);
		check_bit("joypad_data[1]", joypad_data[1], 1'b0);
		check_flags("mapper_flags", mapper_flags, '0);
		report_test("reset_values", errs);
	endtask

	task automatic normal_load();
		ines_header_t  hdr;
		mapper_flags_t exp_flags;
		rom_addr_t     exp_addr;
		logic          seen;
		int            errs;
		int            base;
		int            n;
		errs = error_count;
		base = cap_addr.size();
		exp_mem.delete();
		hdr = '0;
		hdr[31:0]  = INES_MAGIC;
		hdr[39:32] = 8'd1;                  // One 16 KiB PRG page
		hdr[47:40] = 8'd1;                  // One 8 KiB CHR page
		hdr[55:48] = 8'h11;                 // Mapper low nibble 1 and mirroring bit
		send_file(hdr, 16384, 8192);
		wait_done(seen);
		end_download();
		n = cap_addr.size() - base;
		if (n != 24576) begin
			$display("Memory was written %0d times instead of 24576", n);
			error_count++;
		end
		if (n > 24576)
			n = 24576;
		for (int j = 0; j < n; j++) begin
			exp_addr = (j < 16384) ? rom_addr_t'(j) : CHR_BASE + rom_addr_t'(j - 16384);
			check_addr("mem_addr", cap_addr[base + j], exp_addr);
			check_byte("mem_data", cap_data[base + j], exp_mem[exp_addr]);
		end
		exp_flags           = '0;
		exp_flags.mapper    = 8'h01;
		exp_flags.mirroring = 1'b1;
		check_bit("loader_done", loader_done, 1'b1);
		check_bit("loader_fail", loader_fail, 1'b0);
		check_bit("loader_busy", loader_busy, 1'b0);
		check_flags("mapper_flags", mapper_flags, exp_flags);
		report_test("normal_load", errs);
	endtask

	task automatic load_header_only(input ines_header_t hdr, input mapper_flags_t exp);
		logic seen;
		int   base;
		base = cap_addr.size();
		send_file(hdr, 0, 0);
		wait_done(seen);
		end_download();
		check_bit("loader_done", loader_done, 1'b1);
		check_bit("loader_fail", loader_fail, 1'b0);
		check_flags("mapper_flags", mapper_flags, exp);
		expect_no_writes(base);
	endtask

	task automatic header_variants();
		ines_header_t  hdr;
		mapper_flags_t exp_flags;
		int            errs;
		errs = error_count;
		hdr = '0;
		hdr[31:0]   = INES_MAGIC;
		hdr[55:48]  = 8'h30;
		hdr[63:56]  = 8'h40;                // Upper nibble lost on a dirty header
		hdr[103:96] = 8'h5A;                // Byte 12 holds ripper junk
		exp_flags         = '0;
		exp_flags.mapper  = 8'h03;
		exp_flags.chr_ram = 1'b1;
		load_header_only(hdr, exp_flags);

		@(posedge clk);
		invert_mirroring <= 1'b1;
		hdr = '0;
		hdr[31:0]  = INES_MAGIC;
		hdr[55:48] = 8'h03;                 // Mirroring and battery
		hdr[63:56] = 8'h28;                 // NES 2.0 with mapper upper nibble 2
		hdr[71:64] = 8'h35;
		hdr[87:80] = 8'h07;                 // Byte 10 is valid data in NES 2.0
		exp_flags           = '0;
		exp_flags.mapper    = 8'h20;
		exp_flags.chr_ram   = 1'b1;
		exp_flags.submapper = 8'h35;
		exp_flags.has_saves = 1'b1;
		load_header_only(hdr, exp_flags);
		@(posedge clk);
		invert_mirroring <= 1'b0;
		report_test("header_variants", errs);
	endtask

	task automatic load_rejected(input ines_header_t hdr);
		logic seen;
		int   base;
		base = cap_addr.size();
		send_file(hdr, 0, 0);
		wait_done(seen);
		for (int i = 0; i < 4; i++) begin   // Data after a reject goes nowhere
			rng = xorshift32(rng);
			send_byte(rng[7:0]);
		end
		end_download();
		check_bit("loader_done", loader_done, 1'b1);
		check_bit("loader_fail", loader_fail, 1'b1);
		expect_no_writes(base);
	endtask

	task automatic rejected_header();
		ines_header_t hdr;
		int           errs;
		errs = error_count;
		hdr = '0;
		hdr[31:0]  = INES_MAGIC;
		hdr[7:0]   = 8'h4D;                 // Corrupt first magic byte
		hdr[39:32] = 8'd1;
		load_rejected(hdr);
		hdr[31:0]  = INES_MAGIC;
		hdr[55:48] = 8'h04;                 // Trainer present
		load_rejected(hdr);
		report_test("rejected_header", errs);
	endtask

	task automatic cheat_code_load();
		byte_t       cb [16];
		cheat_code_t exp_code;
		logic        seen;
		int          errs;
		int          base_pulses;
		int          base_caps;
		errs        = error_count;
		base_pulses = valid_pulses;
		base_caps   = cap_addr.size();
		for (int i = 0; i < 16; i++) begin
			rng   = xorshift32(rng);
			cb[i] = rng[7:0];
		end
		exp_code.flags   = {cb[3], cb[2], cb[1], cb[0]};
		exp_code.address = {cb[7], cb[6], cb[5], cb[4]};
		exp_code.compare = {cb[11], cb[10], cb[9], cb[8]};
		exp_code.replace = {cb[15], cb[14], cb[13], cb[12]};
		start_download(CHEAT_FILE_INDEX);
		for (int i = 0; i < 16; i++)
			send_byte(cb[i]);
		wait_cheat_valid(base_pulses, seen);
		// Loader still holds the rejected load, a restart would clear done
		check_bit("loader_done", loader_done, 1'b1);
		check_bit("loader_fail", loader_fail, 1'b1);
		check_bit("loader_busy", loader_busy, 1'b0);
		repeat (4) @(negedge clk);
		end_download();
		check_code("cheat_code", cheat_code, exp_code);
		if (valid_pulses - base_pulses != 1) begin
			$display("cheat_valid pulsed %0d times instead of once", valid_pulses - base_pulses);
			error_count++;
		end
		expect_no_writes(base_caps);
		report_test("cheat_code_load", errs);
	endtask

	// Latch then read both ports through 24 falling clock edges
	task automatic shift_ports(input logic [23:0] exp0, input logic [23:0] exp1);
		@(posedge clk);
		joypad_strobe <= 1'b1;
		@(posedge clk);
		joypad_strobe <= 1'b0;
		@(negedge clk);
		for (int i = 0; i < 24; i++) begin
			check_bit($sformatf("joypad_data[0] bit %0d", i), joypad_data[0], exp0[i]);
			check_bit($sformatf("joypad_data[1] bit %0d", i), joypad_data[1], exp1[i]);
			@(posedge clk);
			joypad_clock <= 2'b11;
			@(posedge clk);
			joypad_clock <= 2'b00;
			@(posedge clk);
			@(negedge clk);
		end
		check_bit("joypad_data[0] after 24 shifts", joypad_data[0], 1'b0);
		check_bit("joypad_data[1] after 24 shifts", joypad_data[1], 1'b0);
	endtask

	task automatic controllers();
		int errs;
		errs = error_count;
		@(posedge clk);
		pad_a    <= 8'h35;
		pad_b    <= 8'hC6;
		pad_c    <= 8'h9A;
		pad_d    <= 8'h41;
		joy_swap <= 1'b0;
		multitap <= 1'b0;
		shift_ports({16'hFFFF, 8'h35}, {16'hFFFF, 8'hC6});
		@(posedge clk);
		joy_swap <= 1'b1;
		multitap <= 1'b1;
		shift_ports({TAP_ID_PORT1, 8'h9A, 8'hC6}, {TAP_ID_PORT2, 8'h41, 8'h35});
		report_test("controllers", errs);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		reset_nes        = 1'b1;
		download         = 1'b0;
		file_index       = 8'h00;
		file_byte        = 8'h00;
		byte_strobe      = 1'b0;
		invert_mirroring = 1'b0;
		joy_swap         = 1'b0;
		multitap         = 1'b0;
		pad_a            = 8'h00;
		pad_b            = 8'h00;
		pad_c            = 8'h00;
		pad_d            = 8'h00;
		joypad_strobe    = 1'b0;
		joypad_clock     = 2'b00;
		error_count      = 0;
		check_count      = 0;
		tests_run        = 0;
		timed_out        = 1'b0;
		rng              = 32'd40231;
		repeat (3) @(posedge clk);
		reset_nes <= 1'b0;
		@(negedge clk);

		reset_values();
		normal_load();
		if (!timed_out)
			header_variants();
		if (!timed_out)
			rejected_header();
		if (!timed_out)
			cheat_code_load();
		if (!timed_out)
			controllers();

		$display("%0d tests, %0d checks, %0d errors", tests_run, check_count, error_count);
		if (error_count == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

/* src.f */
hdl/nes_cart_pkg.sv
hdl/ines_decode.sv
hdl/rom_loader.sv
hdl/cheat_assembler.sv
hdl/joypad_serializer.sv
hdl/cart_frontend.sv
tests/tb_cart_frontend.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f src.f \
	--top-module tb_cart_frontend -o tb_cart_frontend
./obj_dir/tb_cart_frontend > sim.log
cat sim.log

if grep -q "^TEST PASS$" sim.log; then
	exit 0
fi
exit 1
